// ==== hdl/sdram_macros.svh ====
// SDRAM map constants: word address width, region bases and download split
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// SDRAM word address width
`define SDRAMW 23

// Word bases in bank 0
`define ROM_OFFSET  23'h00_0000
`define VRAM_OFFSET 23'h20_0000
`define WRAM_OFFSET 23'h30_0000
`define SND_OFFSET  23'h38_0000

// Word base in bank 1
`define GFX_OFFSET  23'h00_0000

// Download byte address where graphics start
`define GFX_START   26'h80_0000

`endif

// ==== hdl/sdram_pkg.sv ====
// SDRAM slot subsystem types: memory regions and slot access kinds
`default_nettype none

package sdram_pkg;

    // Regions of the SDRAM map, each with its own word base
    typedef enum logic [2:0] {
        ROM,    // Main CPU program
        VRAM,   // Video RAM, bank 0
        WRAM,   // Main CPU work RAM
        SND,    // Sound CPU program
        GFX     // Graphics, bank 1
    } region_t;

    // Whether a client may write through its slot
    typedef enum logic {
        SLOT_RO,
        SLOT_RW
    } slot_kind_t;

endpackage

`default_nettype wire

// ==== hdl/slot_if.sv ====
// Slot request channel between a client front end and its bank arbiter
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

interface slot_if;
    logic [`SDRAMW-1:0] addr;
    logic               req;    // Held until ack
    logic               we;
    logic [15:0]        din;
    logic [ 1:0]        mask;   // Set bit keeps that byte
    logic               ack;
    logic               rdy;    // One-cycle strobe
    logic [15:0]        dout;

    modport slot (
        output addr, req, we, din, mask,
        input  ack, rdy, dout
    );

    modport arbiter (
        input  addr, req, we, din, mask,
        output ack, rdy, dout
    );
endinterface

`default_nettype wire

// ==== hdl/slot_cache.sv ====
// Client front end: latches the last fetched line and turns cs into slot requests
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

module slot_cache #(
    parameter int                   AW   = 16,
    parameter int                   DW   = 16,   // 8, 16 or 32
    parameter sdram_pkg::slot_kind_t KIND = sdram_pkg::SLOT_RO
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cs,
    input  logic [AW-1:0]     addr,    // Byte address for DW 8, DW word otherwise
    input  logic [`SDRAMW-1:0] offset,
    input  logic              wen,
    input  logic [15:0]       din,
    input  logic [ 1:0]       wrmask,
    output logic              ok,
    output logic [DW-1:0]     dout,
    slot_if.slot              slot
);

    localparam int SW = `SDRAMW;
    localparam bit RW = (KIND == sdram_pkg::SLOT_RW);

    logic [SW-1:0]    word_addr;
    logic [SW-1:0]    full_addr;
    logic [SW-1:0]    line_addr;
    logic [SW+AW-1:0] cur_tag;
    logic [SW+AW-1:0] ok_tag;    // Request that ok belongs to
    logic [31:0]      line_data; // New words shift in from the top
    logic             line_valid;
    logic             busy;
    logic             second;    // Odd word of a 32-bit line
    logic             wr_en;
    logic             hit;

    // A 32-bit line starts at the even SDRAM word
    always_comb begin
        if (DW == 8)
            word_addr = SW'(addr >> 1);
        else if (DW == 16)
            word_addr = SW'(addr);
        else
            word_addr = SW'({addr, 1'b0});
    end

    assign wr_en     = RW && wen;
    assign full_addr = offset + word_addr;
    assign cur_tag   = {offset, addr};
    assign hit       = line_valid && (line_addr == full_addr) && !wr_en;

    always_comb begin
        if (DW == 8)
            dout = DW'(addr[0] ? line_data[31:24] : line_data[23:16]); // Odd byte is high
        else if (DW == 16)
            dout = DW'(line_data[31:16]);
        else
            dout = DW'(line_data);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ok         <= 1'b0;
            busy       <= 1'b0;
            second     <= 1'b0;
            line_valid <= 1'b0;
            slot.req   <= 1'b0;
        end else begin
            if (busy) begin
                if (slot.ack)
                    slot.req <= 1'b0;
                if (slot.rdy) begin
                    line_data <= {slot.dout, line_data[31:16]};
                    if (DW == 32 && !second) begin
                        second    <= 1'b1;        // Low word done, fetch the odd one
                        slot.req  <= 1'b1;
                        slot.addr <= slot.addr + 1'b1;
                    end else begin
                        busy       <= 1'b0;
                        second     <= 1'b0;
                        line_valid <= !slot.we;   // Writes leave the latch empty
                        ok         <= cs && (cur_tag == ok_tag);
                    end
                end
            end else if (ok) begin
                ok <= cs && (cur_tag == ok_tag);
            end else if (cs) begin
                ok_tag <= cur_tag;
                if (hit) begin
                    ok <= 1'b1;
                end else begin
                    busy       <= 1'b1;
                    line_valid <= 1'b0;
                    line_addr  <= full_addr;
                    slot.req   <= 1'b1;
                    slot.addr  <= full_addr;
                    slot.we    <= wr_en;
                    slot.din   <= din;
                    slot.mask  <= wrmask;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bank_arbiter.sv ====
// Fixed-priority arbiter serving several slots on one SDRAM bank port
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

module bank_arbiter #(
    parameter int NSLOT = 2
) (
    input  logic               clk,
    input  logic               reset,
    slot_if.arbiter            slots [NSLOT],
    output logic [`SDRAMW-1:0] sdram_addr,
    output logic               sdram_rd,
    output logic               sdram_wr,
    output logic [15:0]        sdram_din,
    output logic [ 1:0]        sdram_mask,
    input  logic               sdram_ack,
    input  logic               sdram_rdy,
    input  logic [15:0]        data_read
);

    localparam int OW = (NSLOT > 1) ? $clog2(NSLOT) : 1;

    localparam logic [1:0] IDLE     = 2'd0,
                           WAIT_ACK = 2'd1,
                           WAIT_RDY = 2'd2;

    logic [1:0]         state;
    logic [OW-1:0]      owner;
    logic [OW-1:0]      sel;
    logic               any_req;
    logic [NSLOT-1:0]   req_v;
    logic [NSLOT-1:0]   we_v;
    logic [`SDRAMW-1:0] addr_v [NSLOT];
    logic [15:0]        din_v  [NSLOT];
    logic [ 1:0]        mask_v [NSLOT];

    // Interface arrays take constant indexes only
    for (genvar i = 0; i < NSLOT; i++) begin : g_slot
        assign req_v[i]  = slots[i].req;
        assign we_v[i]   = slots[i].we;
        assign addr_v[i] = slots[i].addr;
        assign din_v[i]  = slots[i].din;
        assign mask_v[i] = slots[i].mask;

        assign slots[i].ack  = sdram_ack && (state == WAIT_ACK) && (owner == OW'(i));
        assign slots[i].rdy  = sdram_rdy && (state == WAIT_RDY) && (owner == OW'(i));
        assign slots[i].dout = data_read;
    end

    // Lowest index wins
    always_comb begin
        sel     = '0;
        any_req = 1'b0;
        for (int i = NSLOT - 1; i >= 0; i--) begin
            if (req_v[i]) begin
                sel     = OW'(i);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            owner    <= '0;
            sdram_rd <= 1'b0;
            sdram_wr <= 1'b0;
        end else begin
            case (state)
                IDLE: if (any_req) begin
                    owner      <= sel;
                    sdram_addr <= addr_v[sel];
                    sdram_din  <= din_v[sel];
                    sdram_mask <= mask_v[sel];
                    sdram_rd   <= !we_v[sel];
                    sdram_wr   <= we_v[sel];
                    state      <= WAIT_ACK;
                end
                WAIT_ACK: if (sdram_ack) begin
                    sdram_rd <= 1'b0;           // Bank has taken the access
                    sdram_wr <= 1'b0;
                    state    <= WAIT_RDY;
                end
                WAIT_RDY: if (sdram_rdy)
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/prog_writer.sv ====
// Download writer: turns ROM load bytes into masked 16-bit SDRAM writes
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

module prog_writer (
    input  logic               clk,
    input  logic               reset,
    input  logic               downloading,
    input  logic [25:0]        ioctl_addr,
    input  logic [ 7:0]        ioctl_dout,
    input  logic               ioctl_wr,
    output logic [`SDRAMW-1:0] prog_addr,
    output logic [15:0]        prog_data,
    output logic [ 1:0]        prog_mask,
    output logic [ 1:0]        prog_ba,
    output logic               prog_we,
    input  logic               prog_rdy,
    output logic               dwnld_busy
);

    localparam int SW = `SDRAMW;

    logic        is_gfx;
    logic [25:0] rel_addr;
    logic        take;

    assign take       = ioctl_wr && downloading;
    assign is_gfx     = (ioctl_addr >= `GFX_START);
    assign rel_addr   = is_gfx ? ioctl_addr - `GFX_START : ioctl_addr; // Bank 1 is rebased
    assign dwnld_busy = downloading || prog_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else begin
            if (prog_we && prog_rdy)
                prog_we <= 1'b0;
            if (take)
                prog_we <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prog_addr <= SW'(rel_addr >> 1);
            prog_data <= {2{ioctl_dout}};
            // Odd byte goes high, so the low byte is kept
            prog_mask <= {~ioctl_addr[0], ioctl_addr[0]};
            prog_ba   <= is_gfx ? 2'd1 : 2'd0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdram_mux.sv ====
// Arcade SDRAM slot top: client slots, two bank arbiters and the download writer
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_mux (
    input  logic               clk,
    input  logic               reset,
    // ROM download
    input  logic               downloading,
    input  logic [25:0]        ioctl_addr,
    input  logic [ 7:0]        ioctl_dout,
    input  logic               ioctl_wr,
    output logic [`SDRAMW-1:0] prog_addr,
    output logic [15:0]        prog_data,
    output logic [ 1:0]        prog_mask,
    output logic [ 1:0]        prog_ba,
    output logic               prog_we,
    input  logic               prog_rdy,
    output logic               dwnld_busy,
    // Main CPU ROM
    input  logic               main_rom_cs,
    input  logic [20:0]        main_rom_addr,
    output logic               main_rom_ok,
    output logic [15:0]        main_rom_data,
    // Main CPU work RAM and VRAM
    input  logic               main_ram_cs,
    input  logic               main_vram_cs,
    input  logic [16:0]        main_ram_addr,
    input  logic               main_rnw,
    input  logic [15:0]        main_ram_din,
    input  logic [ 1:0]        main_ram_dsn,   // Set bit leaves that byte alone
    output logic               main_ram_ok,
    output logic [15:0]        main_ram_data,
    // Sound CPU, byte addressed
    input  logic               snd_cs,
    input  logic [15:0]        snd_addr,
    output logic               snd_ok,
    output logic [ 7:0]        snd_data,
    // Graphics readers
    input  logic               gfx0_cs,
    input  logic [19:0]        gfx0_addr,
    output logic               gfx0_ok,
    output logic [31:0]        gfx0_data,
    input  logic               gfx1_cs,
    input  logic [19:0]        gfx1_addr,
    output logic               gfx1_ok,
    output logic [31:0]        gfx1_data,
    // Bank 0
    output logic [`SDRAMW-1:0] ba0_addr,
    output logic               ba0_rd,
    output logic               ba0_wr,
    output logic [15:0]        ba0_din,
    output logic [ 1:0]        ba0_din_m,
    input  logic               ba0_ack,
    input  logic               ba0_rdy,
    // Bank 1, read only
    output logic [`SDRAMW-1:0] ba1_addr,
    output logic               ba1_rd,
    input  logic               ba1_ack,
    input  logic               ba1_rdy,
    input  logic [15:0]        data_read
);

    function automatic logic [`SDRAMW-1:0] region_offset(input sdram_pkg::region_t r);
        case (r)
            sdram_pkg::ROM:  return `ROM_OFFSET;
            sdram_pkg::VRAM: return `VRAM_OFFSET;
            sdram_pkg::WRAM: return `WRAM_OFFSET;
            sdram_pkg::SND:  return `SND_OFFSET;
            default:         return `GFX_OFFSET;
        endcase
    endfunction

    sdram_pkg::region_t ram_region;
    logic               ram_cs;

    assign ram_cs     = main_ram_cs || main_vram_cs;
    assign ram_region = main_ram_cs ? sdram_pkg::WRAM : sdram_pkg::VRAM;

    slot_if ba0_slot [3] ();   // 0 RAM, 1 ROM, 2 sound
    slot_if ba1_slot [2] ();   // 0 gfx0, 1 gfx1

    slot_cache #(.AW(17), .DW(16), .KIND(sdram_pkg::SLOT_RW)) u_ram (
        .clk(clk), .reset(reset), .cs(ram_cs), .addr(main_ram_addr),
        .offset(region_offset(ram_region)), .wen(!main_rnw),
        .din(main_ram_din), .wrmask(main_ram_dsn),
        .ok(main_ram_ok), .dout(main_ram_data), .slot(ba0_slot[0])
    );

    slot_cache #(.AW(21), .DW(16), .KIND(sdram_pkg::SLOT_RO)) u_rom (
        .clk(clk), .reset(reset), .cs(main_rom_cs), .addr(main_rom_addr),
        .offset(region_offset(sdram_pkg::ROM)), .wen(1'b0), .din(16'd0), .wrmask(2'b11),
        .ok(main_rom_ok), .dout(main_rom_data), .slot(ba0_slot[1])
    );

    slot_cache #(.AW(16), .DW(8), .KIND(sdram_pkg::SLOT_RO)) u_snd (
        .clk(clk), .reset(reset), .cs(snd_cs), .addr(snd_addr),
        .offset(region_offset(sdram_pkg::SND)), .wen(1'b0), .din(16'd0), .wrmask(2'b11),
        .ok(snd_ok), .dout(snd_data), .slot(ba0_slot[2])
    );

    slot_cache #(.AW(20), .DW(32), .KIND(sdram_pkg::SLOT_RO)) u_gfx0 (
        .clk(clk), .reset(reset), .cs(gfx0_cs), .addr(gfx0_addr),
        .offset(region_offset(sdram_pkg::GFX)), .wen(1'b0), .din(16'd0), .wrmask(2'b11),
        .ok(gfx0_ok), .dout(gfx0_data), .slot(ba1_slot[0])
    );

    slot_cache #(.AW(20), .DW(32), .KIND(sdram_pkg::SLOT_RO)) u_gfx1 (
        .clk(clk), .reset(reset), .cs(gfx1_cs), .addr(gfx1_addr),
        .offset(region_offset(sdram_pkg::GFX)), .wen(1'b0), .din(16'd0), .wrmask(2'b11),
        .ok(gfx1_ok), .dout(gfx1_data), .slot(ba1_slot[1])
    );

    bank_arbiter #(.NSLOT(3)) u_bank0 (
        .clk(clk), .reset(reset), .slots(ba0_slot),
        .sdram_addr(ba0_addr), .sdram_rd(ba0_rd), .sdram_wr(ba0_wr),
        .sdram_din(ba0_din), .sdram_mask(ba0_din_m),
        .sdram_ack(ba0_ack), .sdram_rdy(ba0_rdy), .data_read(data_read)
    );

    // Graphics never write, so the write side of this port stays open
    bank_arbiter #(.NSLOT(2)) u_bank1 (
        .clk(clk), .reset(reset), .slots(ba1_slot),
        .sdram_addr(ba1_addr), .sdram_rd(ba1_rd), .sdram_wr(),
        .sdram_din(), .sdram_mask(),
        .sdram_ack(ba1_ack), .sdram_rdy(ba1_rdy), .data_read(data_read)
    );

    prog_writer u_prog (
        .clk(clk), .reset(reset), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_ba(prog_ba), .prog_we(prog_we), .prog_rdy(prog_rdy),
        .dwnld_busy(dwnld_busy)
    );

endmodule

`default_nettype wire

// ==== bench/sdram_mux_props.sv ====
// SDRAM handshake properties for the slot subsystem, bound to the top level
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_mux_props (
    input logic               clk,
    input logic               reset,
    input logic [`SDRAMW-1:0] ba0_addr,
    input logic               ba0_rd,
    input logic               ba0_wr,
    input logic               ba0_ack,
    input logic               ba0_rdy,
    input logic [`SDRAMW-1:0] ba1_addr,
    input logic               ba1_rd,
    input logic               ba1_ack,
    input logic               ba1_rdy,
    input logic               main_rom_ok,
    input logic               main_ram_ok,
    input logic               snd_ok,
    input logic               gfx0_ok,
    input logic               gfx1_ok
);

    logic busy0;    // Access acknowledged and rdy still to come
    logic busy1;
    int   fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy0 <= 1'b0;
            busy1 <= 1'b0;
        end else begin
            busy0 <= ba0_ack ? 1'b1 : (ba0_rdy ? 1'b0 : busy0);
            busy1 <= ba1_ack ? 1'b1 : (ba1_rdy ? 1'b0 : busy1);
        end
    end

    a_ba0_hold: assert property (@(posedge clk) disable iff (reset)
        ((ba0_rd || ba0_wr) && !ba0_ack) |=> (ba0_rd || ba0_wr) && $stable(ba0_addr))
        else begin
            fail_count++;
            $error("bank 0 request dropped or changed before ack");
        end
    a_ba1_hold: assert property (@(posedge clk) disable iff (reset)
        (ba1_rd && !ba1_ack) |=> ba1_rd && $stable(ba1_addr))
        else begin
            fail_count++;
            $error("bank 1 request dropped or changed before ack");
        end
    a_ba0_rdwr: assert property (@(posedge clk) disable iff (reset) !(ba0_rd && ba0_wr))
        else begin
            fail_count++;
            $error("bank 0 rd and wr high together");
        end
    a_ba0_single: assert property (@(posedge clk) disable iff (reset)
        busy0 |-> !(ba0_rd || ba0_wr))
        else begin
            fail_count++;
            $error("bank 0 request started before rdy");
        end
    a_ba1_single: assert property (@(posedge clk) disable iff (reset) busy1 |-> !ba1_rd)
        else begin
            fail_count++;
            $error("bank 1 request started before rdy");
        end
    a_ok_reset: assert property (@(posedge clk)
        reset |=> !(main_rom_ok || main_ram_ok || snd_ok || gfx0_ok || gfx1_ok))
        else begin
            fail_count++;
            $error("client ok high during reset");
        end

endmodule

bind sdram_mux sdram_mux_props u_props (.*);

`default_nettype wire

// ==== bench/sdram_mux_tb.sv ====
// Testbench for the SDRAM slot top: bank models, random clients and a reference memory
`timescale 1ns/1ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_mux_tb;

    localparam int NTRANS = 300;    // Transactions in the test sequence

    logic clk = 1'b0, reset;
    logic downloading, ioctl_wr, prog_we, prog_rdy, dwnld_busy;
    logic [25:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic [22:0] prog_addr, ba0_addr, ba1_addr;
    logic [15:0] prog_data, main_rom_data, main_ram_din, main_ram_data, ba0_din, data_read;
    logic [1:0]  prog_mask, prog_ba, main_ram_dsn, ba0_din_m;
    logic        main_rom_cs, main_rom_ok, main_ram_cs, main_vram_cs, main_rnw, main_ram_ok;
    logic [20:0] main_rom_addr;
    logic [16:0] main_ram_addr;
    logic        snd_cs, snd_ok, gfx0_cs, gfx0_ok, gfx1_cs, gfx1_ok;
    logic [15:0] snd_addr;
    logic [7:0]  snd_data;
    logic [19:0] gfx0_addr, gfx1_addr;
    logic [31:0] gfx0_data, gfx1_data;
    logic        ba0_rd, ba0_wr, ba0_ack, ba0_rdy, ba1_rd, ba1_ack, ba1_rdy;

    int errors = 0;
    int seed = 48025;
    logic [15:0] sdram [logic [23:0]];    // Bank model contents
    logic [15:0] ref_mem [logic [23:0]];  // Expected contents

    sdram_mux UUT (.*);

    always #2 clk = ~clk;

    initial begin
        #(NTRANS * 200 * 4);
        $display("Timeout: the DUT stopped answering and the run hung");
        $display("ERRORS FOUND");
        $finish;
    end

    // Unwritten words depend on every address bit
    function automatic logic [15:0] fill(input logic bank, input logic [22:0] a);
        return {a[7:0] ^ a[22:15], a[15:8] ^ {bank, a[22:16]}};
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, nw, input logic [1:0] m);
        return {m[1] ? old[15:8] : nw[15:8], m[0] ? old[7:0] : nw[7:0]};
    endfunction

    function automatic logic [15:0] sd_read(input logic bank, input logic [22:0] a);
        return sdram.exists({bank, a}) ? sdram[{bank, a}] : fill(bank, a);
    endfunction

    function automatic logic [15:0] ref_read(input logic bank, input logic [22:0] a);
        return ref_mem.exists({bank, a}) ? ref_mem[{bank, a}] : fill(bank, a);
    endfunction

    function automatic logic [22:0] region_base(input sdram_pkg::region_t r);
        case (r)
            sdram_pkg::VRAM: return `VRAM_OFFSET;
            sdram_pkg::WRAM: return `WRAM_OFFSET;
            sdram_pkg::SND:  return `SND_OFFSET;
            sdram_pkg::GFX:  return `GFX_OFFSET;
            default:         return `ROM_OFFSET;
        endcase
    endfunction

    task automatic ref_write(input logic bank, input logic [22:0] a, input logic [15:0] d,
                             input logic [1:0] m);
        ref_mem[{bank, a}] = merge(ref_read(bank, a), d, m);
    endtask

    // Bank and download models, acting 1 ns after each edge
    int st0 = 0, cnt0, st1 = 0, cnt1, stp = 0, cntp;
    logic [22:0] a0, a1;
    logic        we0;

    always begin
        @(posedge clk);
        #1;
        ba0_ack  = 1'b0;
        ba0_rdy  = 1'b0;
        ba1_ack  = 1'b0;
        ba1_rdy  = 1'b0;
        prog_rdy = 1'b0;
        if (reset) begin
            st0 = 0;
            st1 = 0;
            stp = 0;
        end else begin
            if (st0 == 0 && (ba0_rd || ba0_wr)) begin
                cnt0 = {$random(seed)} % 7;
                st0  = 1;
            end
            if (st0 == 1) begin
                if (cnt0 == 0) begin
                    ba0_ack = 1'b1;
                    a0      = ba0_addr;
                    we0     = ba0_wr;
                    if (ba0_wr)
                        sdram[{1'b0, ba0_addr}] = merge(sd_read(0, ba0_addr), ba0_din, ba0_din_m);
                    cnt0 = 1 + {$random(seed)} % 6;
                    st0  = 2;
                end else
                    cnt0--;
            end else if (st0 == 2) begin
                if (cnt0 > 1)
                    cnt0--;
                else begin
                    ba0_rdy = 1'b1;
                    if (!we0)
                        data_read = sd_read(0, a0);
                    st0 = 0;
                end
            end
            if (st1 == 0 && ba1_rd) begin
                cnt1 = {$random(seed)} % 7;
                st1  = 1;
            end
            if (st1 == 1) begin
                if (cnt1 == 0) begin
                    ba1_ack = 1'b1;
                    a1      = ba1_addr;
                    cnt1    = 1 + {$random(seed)} % 6;
                    st1     = 2;
                end else
                    cnt1--;
            end else if (st1 == 2) begin
                if (cnt1 > 1)
                    cnt1--;
                else if (!ba0_rdy) begin    // data_read is shared with bank 0
                    ba1_rdy   = 1'b1;
                    data_read = sd_read(1, a1);
                    st1       = 0;
                end
            end
            if (stp == 0 && prog_we) begin
                cntp = {$random(seed)} % 4;
                stp  = 1;
            end
            if (stp == 1) begin
                if (cntp == 0) begin
                    prog_rdy = 1'b1;
                    sdram[{prog_ba[0], prog_addr}] =
                        merge(sd_read(prog_ba[0], prog_addr), prog_data, prog_mask);
                    stp = 0;
                end else
                    cntp--;
            end
        end
    end

    task automatic download_byte(input logic [25:0] a, input logic [7:0] d, input logic last);
        logic        bank;
        logic [22:0] wa;
        logic [1:0]  m;
        bank = (a >= `GFX_START);
        wa   = 23'((bank ? a - `GFX_START : a) >> 1);
        m    = a[0] ? 2'b01 : 2'b10;    // Odd byte lives in the high half
        ref_write(bank, wa, {d, d}, m);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        if (last)
            downloading = 1'b0;    // Busy now rests on the pending write alone
        if (!prog_we) begin
            errors++;
            $display("prog_we did not rise one cycle after ioctl_wr at %0t", $time);
        end
        if (prog_addr !== wa || prog_mask !== m || prog_data !== {d, d}
                || prog_ba !== {1'b0, bank}) begin
            errors++;
            $display("ERR %0t: prog write %h/%b/%h/%0d for byte %h", $time,
                     prog_addr, prog_mask, prog_data, prog_ba, a);
        end
        while (prog_we) begin
            if (!dwnld_busy) begin
                errors++;
                $display("dwnld_busy low with a download write pending at %0t", $time);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic rom_read(input logic [20:0] a);
        logic [15:0] exp;
        exp           = ref_read(0, region_base(sdram_pkg::ROM) + 23'(a));
        main_rom_cs   = 1'b1;
        main_rom_addr = a;
        do begin
            @(posedge clk);
            #1;
        end while (!main_rom_ok);
        if (main_rom_data !== exp) begin
            errors++;
            $display("ERR %0t: ROM %h read %h expected %h", $time, a, main_rom_data, exp);
        end
        main_rom_cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic snd_read(input logic [15:0] a);
        logic [15:0] w;
        logic [7:0]  exp;
        w        = ref_read(0, region_base(sdram_pkg::SND) + 23'(a >> 1));
        exp      = a[0] ? w[15:8] : w[7:0];
        snd_cs   = 1'b1;
        snd_addr = a;
        do begin
            @(posedge clk);
            #1;
        end while (!snd_ok);
        if (snd_data !== exp) begin
            errors++;
            $display("ERR %0t: sound %h read %h expected %h", $time, a, snd_data, exp);
        end
        snd_cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic ram_access(input logic vram, input logic [16:0] a, input logic wr,
                              input logic [15:0] d, input logic [1:0] dsn);
        logic [22:0] wa;
        logic [15:0] exp;
        wa = region_base(vram ? sdram_pkg::VRAM : sdram_pkg::WRAM) + 23'(a);
        if (wr)
            ref_write(0, wa, d, dsn);
        exp           = ref_read(0, wa);
        main_ram_cs   = !vram;
        main_vram_cs  = vram;
        main_ram_addr = a;
        main_rnw      = !wr;
        main_ram_din  = d;
        main_ram_dsn  = dsn;
        do begin
            @(posedge clk);
            #1;
        end while (!main_ram_ok);
        if (!wr && main_ram_data !== exp) begin
            errors++;
            $display("ERR %0t: %s %h read %h expected %h", $time, vram ? "VRAM" : "WRAM",
                     a, main_ram_data, exp);
        end
        main_ram_cs  = 1'b0;
        main_vram_cs = 1'b0;
        main_rnw     = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic gfx_read(input int n, input logic [19:0] a);
        logic [22:0] wa;
        logic [31:0] exp;
        logic [31:0] got;
        wa  = region_base(sdram_pkg::GFX) + 23'({a, 1'b0});
        exp = {ref_read(1, wa + 23'd1), ref_read(1, wa)};
        if (n == 0) begin
            gfx0_cs   = 1'b1;
            gfx0_addr = a;
            do begin
                @(posedge clk);
                #1;
            end while (!gfx0_ok);
            got     = gfx0_data;
            gfx0_cs = 1'b0;
        end else begin
            gfx1_cs   = 1'b1;
            gfx1_addr = a;
            do begin
                @(posedge clk);
                #1;
            end while (!gfx1_ok);
            got     = gfx1_data;
            gfx1_cs = 1'b0;
        end
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: gfx%0d %h read %h expected %h", $time, n, a, got, exp);
        end
        @(posedge clk);
        #1;
    endtask

    logic [16:0] ra;
    logic        rv;
    logic [25:0] ba;
    logic [20:0] ma;
    logic [15:0] sa;
    logic [19:0] ga0, ga1;

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        {main_rom_cs, main_ram_cs, main_vram_cs, snd_cs, gfx0_cs, gfx1_cs} = '0;
        {main_rom_addr, main_ram_addr, snd_addr, gfx0_addr, gfx1_addr} = '0;
        main_rnw     = 1'b1;
        main_ram_din = '0;
        main_ram_dsn = 2'b11;
        {ba0_ack, ba0_rdy, ba1_ack, ba1_rdy, prog_rdy} = '0;
        data_read = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        downloading = 1'b1;
        for (int i = 0; i < 128; i++) begin
            ba = 26'({$random(seed)} % 256);
            if (i >= 64)
                ba = ba + `GFX_START;
            else if (i[0])
                ba = ba + {`SND_OFFSET, 1'b0};    // Sound program bytes
            download_byte(ba, 8'($random(seed)), i == 127);
        end
        if (dwnld_busy) begin
            errors++;
            $display("dwnld_busy stayed high after the last download write");
        end

        repeat (20) rom_read(21'({$random(seed)} % 128));
        repeat (20) snd_read(16'({$random(seed)} % 256));
        repeat (10) begin
            ra = 17'({$random(seed)} % 64);
            rv = 1'($random(seed));
            ram_access(rv, ra, 1'b1, 16'($random(seed)), 2'($random(seed)));
            ram_access(rv, ra, 1'b0, 16'h0, 2'b00);
            ram_access(!rv, ra, 1'b0, 16'h0, 2'b00);   // Other region untouched
        end
        repeat (10) begin
            ga0 = 20'({$random(seed)} % 128);
            ga1 = 20'({$random(seed)} % 128);
            fork
                gfx_read(0, ga0);
                gfx_read(1, ga1);
            join
        end
        repeat (10) begin
            ra = 17'({$random(seed)} % 64);
            rom_read(21'(ra));
            rom_read(21'(ra));                      // Served from the latch
            ram_access(1'b0, ra, 1'b0, 16'h0, 2'b00);
            ram_access(1'b0, ra, 1'b1, 16'($random(seed)), 2'b00);
            ram_access(1'b0, ra, 1'b0, 16'h0, 2'b00);
        end
        repeat (10) begin
            ma = 21'({$random(seed)} % 128);
            sa = 16'({$random(seed)} % 256);
            ra = 17'({$random(seed)} % 64);
            fork
                rom_read(ma);
                snd_read(sa);
                ram_access(1'b1, ra, 1'b0, 16'h0, 2'b00);
            join
        end

        errors += UUT.u_props.fail_count;
        $display("Test finished with %0d errors", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/sdram_pkg.sv
hdl/slot_if.sv
hdl/slot_cache.sv
hdl/bank_arbiter.sv
hdl/prog_writer.sv
hdl/sdram_mux.sv
bench/sdram_mux_props.sv
bench/sdram_mux_tb.sv
